//--- src/spi_host_macros.svh
`ifndef SPI_HOST_MACROS_SVH
`define SPI_HOST_MACROS_SVH

// APB address bus width
`define SPI_APB_ADDR_W 8

// APB data bus width, at most 32
`define SPI_APB_DATA_W 32

// Width of the SCK half-period divider register
`define SPI_CLKDIV_W 16

// Divider value out of reset, slow enough for any target
`define SPI_CLKDIV_RESET 100

// Shortest half-period the engine will run, in APB clocks
`define SPI_CLKDIV_MIN 2

`endif

//--- src/spi_host_pkg.sv
`include "spi_host_macros.svh"

package spi_host_pkg;

	////////////////////////////////////////////////////////////
	// Bus and datapath widths

	typedef logic [`SPI_APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`SPI_APB_DATA_W-1:0] apb_data_t;

	// SCK half-period in APB clocks
	typedef logic [`SPI_CLKDIV_W-1:0] clkdiv_t;

	// One SPI transfer
	typedef logic [7:0] spi_byte_t;

	////////////////////////////////////////////////////////////
	// Register map

	// Each register sits on its own 0x20 boundary
	typedef enum apb_addr_t {
		REG_CLK_DIV  = 'h00,
		REG_DATA     = 'h20,
		REG_CS_N     = 'h40,
		REG_STATUS   = 'h60,
		REG_STATUS_2 = 'h80
	} spi_reg_t;

	////////////////////////////////////////////////////////////
	// APB channels

	// Requester to completer
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// Completer to requester
	typedef struct packed {
		logic      pready;
		logic      pslverr;
		apb_data_t prdata;
	} apb_rsp_t;

endpackage

//--- src/spi_shift_engine.sv
`include "spi_host_macros.svh"

module spi_shift_engine (
	input  logic                    apb,
	input  logic                    reset,
	input  spi_host_pkg::clkdiv_t   clkdiv,
	input  logic                    start,
	input  spi_host_pkg::spi_byte_t tx_byte,
	input  logic                    spi_miso,
	output logic                    spi_sck,
	output logic                    spi_mosi,
	output logic                    busy,
	output logic                    done,
	output spi_host_pkg::spi_byte_t rx_byte
);

	// Shift sequencer states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCK_LOW,
		ST_SCK_HIGH
	} shift_state_t;

	shift_state_t            state;
	spi_host_pkg::clkdiv_t   half_period;
	spi_host_pkg::clkdiv_t   half_cnt;
	logic                    half_end;
	logic [2:0]              bit_cnt;
	spi_host_pkg::spi_byte_t tx_shift;
	spi_host_pkg::spi_byte_t rx_shift;

	////////////////////////////////////////////////////////////
	// Half-period timing

	// Clamp tiny dividers so SCK never runs faster than MIN
	assign half_period = (clkdiv < spi_host_pkg::clkdiv_t'(`SPI_CLKDIV_MIN)) ?
		spi_host_pkg::clkdiv_t'(`SPI_CLKDIV_MIN) : clkdiv;

	// Last cycle of the current SCK phase
	assign half_end = (half_cnt == half_period - spi_host_pkg::clkdiv_t'(1));

	////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge apb) begin
		if (reset) begin
			state    <= ST_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			spi_sck  <= 1'b0;
			done     <= 1'b0;
			tx_shift <= '0;
			rx_byte  <= '0;
		end else begin
			done <= 1'b0;

			// Publish the received byte while done is up
			if (done)
				rx_byte <= rx_shift;

			case (state)
				ST_IDLE: begin
					// Bit 7 goes out on MOSI right away, SCK stays low
					if (start) begin
						state    <= ST_SCK_LOW;
						half_cnt <= '0;
						bit_cnt  <= '0;
						tx_shift <= tx_byte;
					end
				end

				ST_SCK_LOW: begin
					if (half_end) begin
						// Rising edge
						half_cnt <= '0;
						spi_sck  <= 1'b1;
						state    <= ST_SCK_HIGH;
					end else begin
						half_cnt <= half_cnt + spi_host_pkg::clkdiv_t'(1);
					end
				end

				ST_SCK_HIGH: begin
					if (half_end) begin
						// Falling edge
						half_cnt <= '0;
						spi_sck  <= 1'b0;
						if (bit_cnt == 3'd7) begin
							state <= ST_IDLE;
							done  <= 1'b1;
						end else begin
							// Next bit onto MOSI
							bit_cnt  <= bit_cnt + 3'd1;
							tx_shift <= {tx_shift[6:0], 1'b0};
							state    <= ST_SCK_LOW;
						end
					end else begin
						half_cnt <= half_cnt + spi_host_pkg::clkdiv_t'(1);
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Sample MISO as SCK rises, MSB first
	always_ff @(posedge apb) begin
		if ((state == ST_SCK_LOW) && half_end)
			rx_shift <= {rx_shift[6:0], spi_miso};
	end

	assign busy     = (state != ST_IDLE);
	assign spi_mosi = tx_shift[7];

endmodule

//--- src/apb_spi_regs.sv
`include "spi_host_macros.svh"

module apb_spi_regs (
	input  logic                    apb,
	input  logic                    reset,
	input  spi_host_pkg::apb_req_t  apb_req,
	output spi_host_pkg::apb_rsp_t  apb_rsp,
	input  logic                    busy,
	input  spi_host_pkg::spi_byte_t rx_byte,
	output logic                    start,
	output spi_host_pkg::spi_byte_t tx_byte,
	output spi_host_pkg::clkdiv_t   clkdiv,
	output logic                    spi_cs_n
);

	logic                    access;
	logic                    addr_hit;
	logic                    addr_ro;
	logic                    wr_ok;
	spi_host_pkg::apb_data_t read_data;

	////////////////////////////////////////////////////////////
	// Address decode

	// Access phase completes in one cycle
	assign access = apb_req.psel & apb_req.penable;

	always_comb begin
		addr_hit = 1'b1;
		addr_ro  = 1'b0;
		case (apb_req.paddr)
			spi_host_pkg::REG_CLK_DIV,
			spi_host_pkg::REG_DATA,
			spi_host_pkg::REG_CS_N: begin
				addr_ro = 1'b0;
			end
			// Both status copies are read only
			spi_host_pkg::REG_STATUS,
			spi_host_pkg::REG_STATUS_2: begin
				addr_ro = 1'b1;
			end
			default: begin
				addr_hit = 1'b0;
			end
		endcase
	end

	// Write that lands on a writable register
	assign wr_ok = access & apb_req.pwrite & addr_hit & ~addr_ro;

	////////////////////////////////////////////////////////////
	// Transfer kick-off

	// Strobe only during the access cycle of a DATA write
	assign start   = wr_ok & (apb_req.paddr == spi_host_pkg::REG_DATA);
	assign tx_byte = start ? apb_req.pwdata[7:0] : '0;

	////////////////////////////////////////////////////////////
	// Register storage

	always_ff @(posedge apb) begin
		if (reset) begin
			clkdiv   <= spi_host_pkg::clkdiv_t'(`SPI_CLKDIV_RESET);
			spi_cs_n <= 1'b1;
		end else if (wr_ok) begin
			case (apb_req.paddr)
				// Upper bits of the write are dropped
				spi_host_pkg::REG_CLK_DIV: clkdiv <= apb_req.pwdata[`SPI_CLKDIV_W-1:0];
				spi_host_pkg::REG_CS_N:    spi_cs_n <= apb_req.pwdata[0];
				default: begin
					spi_cs_n <= spi_cs_n;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux

	// Every field zero-extended to the bus width
	always_comb begin
		read_data = '0;
		case (apb_req.paddr)
			spi_host_pkg::REG_CLK_DIV:  read_data = spi_host_pkg::apb_data_t'(clkdiv);
			spi_host_pkg::REG_DATA:     read_data = spi_host_pkg::apb_data_t'(rx_byte);
			spi_host_pkg::REG_CS_N:     read_data = spi_host_pkg::apb_data_t'(spi_cs_n);
			spi_host_pkg::REG_STATUS:   read_data = spi_host_pkg::apb_data_t'(busy);
			spi_host_pkg::REG_STATUS_2: read_data = spi_host_pkg::apb_data_t'(busy);
			default:                    read_data = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Response

	always_comb begin
		apb_rsp.pready = access;

		// Unmapped address, or a write to a status copy
		apb_rsp.pslverr = access & (~addr_hit | (apb_req.pwrite & addr_ro));

		// Data only on a good read, zero otherwise
		if (access && !apb_req.pwrite && addr_hit)
			apb_rsp.prdata = read_data;
		else
			apb_rsp.prdata = '0;
	end

endmodule

//--- src/apb_spi_host.sv
module apb_spi_host (
	input  logic                   apb,
	input  logic                   reset,
	input  spi_host_pkg::apb_req_t apb_req,
	output spi_host_pkg::apb_rsp_t apb_rsp,
	output logic                   spi_sck,
	output logic                   spi_mosi,
	input  logic                   spi_miso,
	output logic                   spi_cs_n
);

	// Register block to shift engine
	logic                    start;
	spi_host_pkg::spi_byte_t tx_byte;
	spi_host_pkg::clkdiv_t   clkdiv;

	// Shift engine back to register block
	logic                    busy;
	spi_host_pkg::spi_byte_t rx_byte;

	////////////////////////////////////////////////////////////
	// APB registers and chip select

	apb_spi_regs apb_spi_regs_inst (
		.apb      (apb),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.busy     (busy),
		.rx_byte  (rx_byte),
		.start    (start),
		.tx_byte  (tx_byte),
		.clkdiv   (clkdiv),
		.spi_cs_n (spi_cs_n)
	);

	////////////////////////////////////////////////////////////
	// Mode 0 shifter

	// Done pulse is only needed inside the engine
	spi_shift_engine spi_shift_engine_inst (
		.apb      (apb),
		.reset    (reset),
		.clkdiv   (clkdiv),
		.start    (start),
		.tx_byte  (tx_byte),
		.spi_miso (spi_miso),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.busy     (busy),
		.done     (),
		.rx_byte  (rx_byte)
	);

endmodule

//--- bench/apb_spi_host_assert.sv
module apb_spi_host_assert (
	input logic                   apb,
	input logic                   reset,
	input spi_host_pkg::apb_req_t apb_req,
	input spi_host_pkg::apb_rsp_t apb_rsp,
	input logic                   spi_sck,
	input logic                   spi_mosi
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench at the end
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////
	// APB completer rules

	// Zero wait states
	pready_follows_access: assert property (@(posedge apb)
		apb_rsp.pready == (apb_req.psel & apb_req.penable))
	else begin
		fail_count++;
		$error("pready differs from psel and penable");
	end

	// Error only with a completing access
	pslverr_needs_pready: assert property (@(posedge apb)
		apb_rsp.pslverr |-> apb_rsp.pready)
	else begin
		fail_count++;
		$error("pslverr raised without pready");
	end

	////////////////////////////////////////////////////////////
	// SPI pins

	// Mode 0 data holds while SCK is high
	mosi_stable_sck_high: assert property (@(posedge apb) disable iff (reset)
		(spi_sck && $past(spi_sck)) |-> $stable(spi_mosi))
	else begin
		fail_count++;
		$error("spi_mosi changed while spi_sck was high");
	end

	// Idle clock level held in reset
	sck_low_in_reset: assert property (@(posedge apb)
		(reset && $past(reset)) |-> !spi_sck)
	else begin
		fail_count++;
		$error("spi_sck high during reset");
	end

endmodule

//--- bench/apb_spi_host_tb.sv
module apb_spi_host_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Watchdog budget: transfers x 16 half-periods x largest divider
	localparam int NUM_XFERS     = 12;
	localparam int MAX_DIV       = 5;
	localparam int MARGIN_CYCLES = 2000;
	localparam int CLK_PERIOD    = 4;

	logic                   apb = 1'b0;
	logic                   reset;
	spi_host_pkg::apb_req_t apb_req;
	spi_host_pkg::apb_rsp_t apb_rsp;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   spi_miso;
	logic                   spi_cs_n;

	// Rising clock edges so far
	int cycle_cnt = 0;
	// Edge index of the last write's access cycle
	int access_cycle = 0;

	// SPI target model state
	logic                    sck_prev = 1'b0;
	int                      phase_len = 0;
	int                      rise_cnt = 0;
	spi_host_pkg::spi_byte_t cap_byte = '0;
	spi_host_pkg::spi_byte_t resp_shift = '0;
	int                      hi_len[$];
	int                      lo_len[$];

	apb_spi_host apb_spi_host_inst (
		.apb      (apb),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.spi_cs_n (spi_cs_n)
	);

	bind apb_spi_host apb_spi_host_assert apb_spi_host_assert_inst (
		.apb      (apb),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi)
	);

	always #(CLK_PERIOD / 2) apb = ~apb;

	always @(posedge apb) cycle_cnt <= cycle_cnt + 1;

	////////////////////////////////////////////////////////////
	// SPI target, mode 0, looked at on falling APB edges

	always @(negedge apb) begin
		if (spi_sck != sck_prev) begin
			if (spi_sck) begin
				// SCK rose, take MOSI
				cap_byte = {cap_byte[6:0], spi_mosi};
				// Low phases before the first rise are idle time
				if (rise_cnt > 0)
					lo_len.push_back(phase_len);
				rise_cnt++;
			end else begin
				// SCK fell, next response bit
				hi_len.push_back(phase_len);
				resp_shift = {resp_shift[6:0], 1'b0};
				spi_miso = resp_shift[7];
			end
			phase_len = 1;
		end else begin
			phase_len++;
		end
		sck_prev = spi_sck;
	end

	////////////////////////////////////////////////////////////
	// Failure and compare tasks

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "stopping on the first error");
	endtask

	task automatic check_data(input spi_host_pkg::apb_data_t got,
			input spi_host_pkg::apb_data_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_byte(input spi_host_pkg::spi_byte_t got,
			input spi_host_pkg::spi_byte_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			fail_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// APB requester, called and returning on a falling edge

	task automatic apb_write(input spi_host_pkg::apb_addr_t addr,
			input spi_host_pkg::apb_data_t data, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge apb);
		apb_req.penable = 1'b1;
		#1;
		check_bit(apb_rsp.pready, 1'b1, "pready in write access cycle");
		err = apb_rsp.pslverr;
		// Access completes on the coming rising edge
		access_cycle = cycle_cnt + 1;
		@(negedge apb);
		apb_req = '0;
	endtask

	task automatic apb_read(input spi_host_pkg::apb_addr_t addr,
			output spi_host_pkg::apb_data_t data, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		apb_req.pwdata  = '0;
		@(negedge apb);
		apb_req.penable = 1'b1;
		#1;
		check_bit(apb_rsp.pready, 1'b1, "pready in read access cycle");
		data = apb_rsp.prdata;
		err  = apb_rsp.pslverr;
		@(negedge apb);
		apb_req = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Transfer helpers

	// Response byte, bit 7 ready before the first rise
	task automatic load_target(input spi_host_pkg::spi_byte_t resp);
		resp_shift = resp;
		spi_miso   = resp[7];
		rise_cnt   = 0;
		cap_byte   = '0;
		hi_len.delete();
		lo_len.delete();
	endtask

	task automatic wait_idle(output int idle_cycle);
		while (apb_spi_host_inst.busy)
			@(negedge apb);
		idle_cycle = cycle_cnt;
	endtask

	task automatic check_capture(input spi_host_pkg::spi_byte_t tx, input int d);
		check_byte(cap_byte, tx, "byte captured by target");
		check_count(rise_cnt, 8, "SCK rising edges");
		check_count(hi_len.size(), 8, "SCK high phases");
		check_count(lo_len.size(), 7, "SCK low phases");
		foreach (hi_len[i])
			check_count(hi_len[i], d, "SCK high phase length");
		foreach (lo_len[i])
			check_count(lo_len[i], d, "SCK low phase length");
	endtask

	task automatic do_transfer(input spi_host_pkg::spi_byte_t tx,
			input spi_host_pkg::spi_byte_t resp, input int d);
		spi_host_pkg::apb_data_t rd;
		logic                    err;
		int                      start_cycle;
		int                      idle_cycle;
		load_target(resp);
		apb_write(spi_host_pkg::REG_DATA, spi_host_pkg::apb_data_t'(tx), err);
		start_cycle = access_cycle;
		wait_idle(idle_cycle);
		check_count(idle_cycle - start_cycle, 16 * d, "busy length in cycles");
		apb_read(spi_host_pkg::REG_DATA, rd, err);
		check_byte(rd[7:0], resp, "DATA read after transfer");
		check_capture(tx, d);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_values();
		spi_host_pkg::apb_data_t rd;
		logic                    err;
		apb_read(spi_host_pkg::REG_CLK_DIV, rd, err);
		check_data(rd, 32'd100, "CLK_DIV after reset");
		check_bit(err, 1'b0, "pslverr on CLK_DIV read");
		apb_read(spi_host_pkg::REG_CS_N, rd, err);
		check_data(rd, 32'd1, "CS_N after reset");
		apb_read(spi_host_pkg::REG_STATUS, rd, err);
		check_data(rd, 32'd0, "STATUS after reset");
		apb_read(spi_host_pkg::REG_STATUS_2, rd, err);
		check_data(rd, 32'd0, "STATUS_2 after reset");
		check_bit(spi_cs_n, 1'b1, "spi_cs_n after reset");
		check_bit(spi_sck, 1'b0, "spi_sck after reset");
	endtask

	task automatic register_access();
		spi_host_pkg::apb_data_t rd;
		spi_host_pkg::apb_data_t cs_vals[3] = '{32'h0, 32'hffff_ff01, 32'h2};
		logic                    err;
		apb_write(spi_host_pkg::REG_CLK_DIV, 32'h0001_2345, err);
		check_bit(err, 1'b0, "pslverr on CLK_DIV write");
		apb_read(spi_host_pkg::REG_CLK_DIV, rd, err);
		check_data(rd, 32'h0000_2345, "CLK_DIV truncated to 16 bits");
		// Only bit 0 is the chip-select level
		foreach (cs_vals[i]) begin
			apb_write(spi_host_pkg::REG_CS_N, cs_vals[i], err);
			apb_read(spi_host_pkg::REG_CS_N, rd, err);
			check_data(rd, spi_host_pkg::apb_data_t'(cs_vals[i][0]), "CS_N read back");
			check_bit(spi_cs_n, cs_vals[i][0], "spi_cs_n pin");
		end
	endtask

	task automatic single_transfer();
		spi_host_pkg::apb_data_t rd;
		spi_host_pkg::apb_data_t rd2;
		logic                    err;
		int                      start_cycle;
		int                      idle_cycle;
		apb_write(spi_host_pkg::REG_CLK_DIV, 32'd3, err);
		load_target(8'h4b);
		apb_write(spi_host_pkg::REG_DATA, 32'h0000_00d2, err);
		start_cycle = access_cycle;
		apb_read(spi_host_pkg::REG_STATUS, rd, err);
		check_data(rd, 32'd1, "STATUS while busy");
		apb_read(spi_host_pkg::REG_STATUS_2, rd2, err);
		check_data(rd2, 32'd1, "STATUS_2 while busy");
		wait_idle(idle_cycle);
		check_count(idle_cycle - start_cycle, 48, "busy length in cycles");
		apb_read(spi_host_pkg::REG_DATA, rd, err);
		check_data(rd, 32'h0000_004b, "DATA after transfer");
		check_capture(8'hd2, 3);
	endtask

	// Dividers below the minimum run at two cycles per half-period
	task automatic divider_clamp();
		logic err;
		apb_write(spi_host_pkg::REG_CLK_DIV, 32'd0, err);
		do_transfer(8'h96, 8'h69, 2);
		apb_write(spi_host_pkg::REG_CLK_DIV, 32'd1, err);
		do_transfer(8'h0f, 8'hf0, 2);
	endtask

	task automatic error_response();
		spi_host_pkg::apb_addr_t bad_addr[4] = '{8'h04, 8'h1c, 8'ha0, 8'hff};
		spi_host_pkg::apb_data_t rd;
		logic                    err;
		int                      idle_cycle;
		apb_write(spi_host_pkg::REG_CLK_DIV, 32'd4, err);
		foreach (bad_addr[i]) begin
			apb_read(bad_addr[i], rd, err);
			check_bit(err, 1'b1, "pslverr on unmapped read");
			check_data(rd, '0, "prdata on unmapped read");
			apb_write(bad_addr[i], 32'hffff_ffff, err);
			check_bit(err, 1'b1, "pslverr on unmapped write");
		end
		apb_write(spi_host_pkg::REG_STATUS, 32'hffff_ffff, err);
		check_bit(err, 1'b1, "pslverr on STATUS write");
		apb_write(spi_host_pkg::REG_STATUS_2, 32'hffff_ffff, err);
		check_bit(err, 1'b1, "pslverr on STATUS_2 write");
		apb_read(spi_host_pkg::REG_CLK_DIV, rd, err);
		check_data(rd, 32'd4, "CLK_DIV after rejected writes");
		apb_read(spi_host_pkg::REG_CS_N, rd, err);
		check_data(rd, 32'd0, "CS_N after rejected writes");
		// Second DATA write lands mid-transfer
		load_target(8'h3c);
		apb_write(spi_host_pkg::REG_DATA, 32'h0000_00a5, err);
		repeat (5) @(negedge apb);
		apb_write(spi_host_pkg::REG_DATA, 32'h0000_005a, err);
		check_bit(err, 1'b0, "pslverr on DATA write while busy");
		wait_idle(idle_cycle);
		apb_read(spi_host_pkg::REG_DATA, rd, err);
		check_data(rd, 32'h0000_003c, "DATA after ignored write");
		check_capture(8'ha5, 4);
	endtask

	task automatic random_traffic();
		spi_host_pkg::spi_byte_t tx;
		spi_host_pkg::spi_byte_t resp;
		int                      d;
		logic                    err;
		repeat (8) begin
			tx   = spi_host_pkg::spi_byte_t'($urandom());
			resp = spi_host_pkg::spi_byte_t'($urandom());
			d    = 2 + int'($urandom() % 4);
			apb_write(spi_host_pkg::REG_CLK_DIV, spi_host_pkg::apb_data_t'(d), err);
			do_transfer(tx, resp, d);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		void'($urandom(32'hb6f7_2a2e));
		reset    = 1'b1;
		apb_req  = '0;
		spi_miso = 1'b0;
		repeat (4) @(negedge apb);
		reset = 1'b0;
		reset_values();
		register_access();
		single_transfer();
		divider_clamp();
		error_response();
		random_traffic();
		// Bound checks only count their failures
		if (apb_spi_host_inst.apb_spi_host_assert_inst.fail_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			fail_run("Protocol assertions failed during the run");
		end
	end

	initial begin
		#((NUM_XFERS * 16 * MAX_DIV + MARGIN_CYCLES) * CLK_PERIOD);
		fail_run("Watchdog expired: the run timed out before all tests finished");
	end

endmodule

//--- sources.f
+incdir+src
src/spi_host_pkg.sv
src/spi_shift_engine.sv
src/apb_spi_regs.sv
src/apb_spi_host.sv
bench/apb_spi_host_assert.sv
bench/apb_spi_host_tb.sv

//--- Makefile
# Verilator build and run for the APB SPI host testbench
#
#   make compile   build the simulator
#   make run       run it and check the log
#   make clean     remove build output and log

VERILATOR ?= verilator
TOP       ?= apb_spi_host_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides, not the exit status of the simulator
run: $(SIM_BIN)
	@rm -f $(LOG)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx 'Test passed' $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
